//--- build.f
+incdir+.
term_pkg.sv
tick_timer.sv
button_debounce.sv
clear_sequencer.sv
vram_clear.sv
term_front_top.sv
tb_write_checker.sv
tb_term_front.sv

//--- run_sim.sh
#!/bin/sh
# build the testbench with verilator, run it, then scan the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps -f build.f \
  --top-module tb_term_front -o sim_term_front > build.log 2>&1 \
  && ./obj_dir/sim_term_front > sim.log 2>&1 \
  || { cat build.log; echo "build or simulation step failed"; exit 1; }

cat sim.log
grep -q '\*\* FAIL \*\*' sim.log && exit 1 || exit 0

//--- tb_term_front.sv
/*
  terminal front end testbench
  random button glitches, presses and character writes
  checked against the clear and write-port rules
*/

`include "term_settings.svh"

module tb_term_front;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int wait_limit = 500;
  // longest glitch that still spans fewer ticks than the filter needs
  localparam int glitch_max = (`TERM_STABLE_COUNT - 1) * `TERM_SAMPLE_DIV;

  logic                 clk;
  logic                 arst_n;
  logic                 btn_rst;
  logic                 btn_cls;
  logic                 char_we;
  term_pkg::vram_addr_t char_addr;
  term_pkg::char_t      char_data;
  logic                 pix_en;
  logic                 vram_we;
  term_pkg::vram_addr_t vram_addr;
  term_pkg::char_t      vram_data;
  logic                 busy;
  logic [3:0]           led;
  logic                 hold_check;
  logic [1:0]           hold_led;
  logic                 mem_check;
  int                   seed;
  int                   clears_expected;
  int                   exp_writes;
  int                   fail_cnt;
  int                   mark;
  int                   errors;
  int                   checks;
  int                   clears_done;

  term_front_top term_front_top_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .btn_rst   (btn_rst),
    .btn_cls   (btn_cls),
    .char_we   (char_we),
    .char_addr (char_addr),
    .char_data (char_data),
    .pix_en    (pix_en),
    .vram_we   (vram_we),
    .vram_addr (vram_addr),
    .vram_data (vram_data),
    .busy      (busy),
    .led       (led)
  );

  tb_write_checker write_checker_i (
    .clk             (clk),
    .arst_n          (arst_n),
    .char_we         (char_we),
    .char_addr       (char_addr),
    .char_data       (char_data),
    .pix_en          (pix_en),
    .vram_we         (vram_we),
    .vram_addr       (vram_addr),
    .vram_data       (vram_data),
    .busy            (busy),
    .led             (led),
    .clears_expected (clears_expected),
    .exp_writes      (exp_writes),
    .hold_check      (hold_check),
    .hold_led        (hold_led),
    .mem_check       (mem_check),
    .errors          (errors),
    .checks          (checks),
    .clears_done     (clears_done)
  );

  // 4 ns period
  always #2 clk = ~clk;

  // ====================
  // helpers
  // ====================

  // inputs change 1 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) next_cycle();
  endtask

  task automatic wait_led(input logic [1:0] idx, input logic val, input string what);
    int t;
    t = 0;
    while (led[idx] !== val && t < wait_limit) begin
      next_cycle();
      t++;
    end
    if (led[idx] !== val) begin
      fail_cnt++;
      $display("timeout at %0t ns: %s never showed on the leds", $time, what);
    end
  endtask

  task automatic wait_busy(input logic val);
    int t;
    t = 0;
    while (busy !== val && t < wait_limit) begin
      next_cycle();
      t++;
    end
    if (busy !== val) begin
      fail_cnt++;
      $display("timeout at %0t ns: busy stuck at %b", $time, busy);
    end
  endtask

  task automatic wait_clears();
    int t;
    t = 0;
    while (clears_done != clears_expected && t < wait_limit) begin
      next_cycle();
      t++;
    end
    if (clears_done != clears_expected) begin
      fail_cnt++;
      $display("timeout at %0t ns: %0d of %0d clears seen", $time, clears_done,
        clears_expected);
    end
  endtask

  // one full sweep now owed
  task automatic add_clear();
    clears_expected++;
    exp_writes += `TERM_VRAM_DEPTH;
  endtask

  // request held while busy, dropped after the taking edge
  task automatic ext_write(input term_pkg::vram_addr_t addr, input term_pkg::char_t data);
    int t;
    t = 0;
    char_we   = 1'b1;
    char_addr = addr;
    char_data = data;
    while (busy && t < wait_limit) begin
      next_cycle();
      t++;
    end
    if (busy) begin
      fail_cnt++;
      $display("timeout at %0t ns: busy never fell, write at %0d dropped", $time, addr);
    end else begin
      exp_writes++;
    end
    next_cycle();
    char_we = 1'b0;
  endtask

  task automatic button_glitch(input bit on_rst, input int len);
    if (on_rst) btn_rst = 1'b1;
    else btn_cls = 1'b0;
    idle_cycles(len);
    btn_rst = 1'b0;
    btn_cls = 1'b1;
  endtask

  task automatic pulse_mem_check();
    mem_check = 1'b1;
    next_cycle();
    mem_check = 1'b0;
  endtask

  task automatic report_test(input int num, input string name);
    int now;
    now = errors + fail_cnt;
    $display("test %0d %s: %s, %0d new errors", num, name, (now == mark) ? "ok" : "failed",
      now - mark);
    mark = now;
  endtask

  // ====================
  // stimulus
  // ====================

  initial begin
    seed            = 32'h7bc9e54a;
    clk             = 1'b0;
    arst_n          = 1'b0;
    // reset button pressed, clear button released
    btn_rst         = 1'b0;
    btn_cls         = 1'b1;
    char_we         = 1'b0;
    char_addr       = '0;
    char_data       = '0;
    hold_check      = 1'b0;
    // clear level high, system reset low
    hold_led        = 2'b10;
    mem_check       = 1'b0;
    clears_expected = 0;
    exp_writes      = 0;
    fail_cnt        = 0;
    mark            = 0;
    repeat (8) @(posedge clk);
    #1;
    arst_n = 1'b1;

    // short bounces on either button, gaps let the filter start over
    hold_check = 1'b1;
    repeat (8) begin
      button_glitch(1'($random(seed)), 1 + int'($unsigned($random(seed)) % glitch_max));
      idle_cycles(2 * `TERM_SAMPLE_DIV + int'($unsigned($random(seed)) % `TERM_SAMPLE_DIV));
    end
    hold_check = 1'b0;
    btn_rst    = 1'b1;
    add_clear();
    wait_led(2'd0, 1'b1, "reset release");
    report_test(1, "button glitch filter");

    wait_clears();
    wait_busy(1'b0);
    report_test(2, "clear after reset release");

    repeat (16) begin
      ext_write(term_pkg::vram_addr_t'($random(seed)), term_pkg::char_t'($random(seed)));
      idle_cycles(int'($unsigned($random(seed)) % 4));
    end
    idle_cycles(2);
    pulse_mem_check();
    report_test(3, "external writes while idle");

    btn_cls = 1'b0;
    add_clear();
    wait_led(2'd1, 1'b0, "clear press");
    wait_busy(1'b1);
    ext_write(term_pkg::vram_addr_t'($random(seed)), term_pkg::char_t'($random(seed)));
    btn_cls = 1'b1;
    wait_led(2'd1, 1'b1, "clear release");
    wait_clears();
    wait_busy(1'b0);
    idle_cycles(2);
    pulse_mem_check();
    report_test(4, "write held during clear");

    // second press right behind the first
    btn_cls = 1'b0;
    add_clear();
    wait_led(2'd1, 1'b0, "first clear press");
    wait_busy(1'b1);
    btn_cls = 1'b1;
    wait_led(2'd1, 1'b1, "first clear release");
    btn_cls = 1'b0;
    add_clear();
    wait_led(2'd1, 1'b0, "second clear press");
    btn_cls = 1'b1;
    wait_led(2'd1, 1'b1, "second clear release");
    wait_clears();
    wait_busy(1'b0);
    idle_cycles(2);
    pulse_mem_check();
    report_test(5, "two clear presses");

    idle_cycles(4);
    $display("tests 5, checks %0d, mismatches %0d, other failures %0d", checks, errors,
      fail_cnt);
    if (errors == 0 && fail_cnt == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

//--- tb_write_checker.sv
/*
  write port checker
  watches the character memory port, leds and pixel enable
  and compares them with a model of the clear and write rules
*/

`include "term_settings.svh"

module tb_write_checker (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 char_we,
  input  term_pkg::vram_addr_t char_addr,
  input  term_pkg::char_t      char_data,
  input  logic                 pix_en,
  input  logic                 vram_we,
  input  term_pkg::vram_addr_t vram_addr,
  input  term_pkg::char_t      vram_data,
  input  logic                 busy,
  input  logic [3:0]           led,
  input  int                   clears_expected,
  input  int                   exp_writes,
  input  logic                 hold_check,
  input  logic [1:0]           hold_led,
  input  logic                 mem_check,
  output int                   errors,
  output int                   checks,
  output int                   clears_done
);

  timeunit 1ns;
  timeprecision 100ps;

  localparam term_pkg::char_t blank = `TERM_BLANK_CODE;

  // model built from the rules, and what the port really wrote
  term_pkg::char_t      model_mem [`TERM_VRAM_DEPTH];
  term_pkg::char_t      actual_mem [`TERM_VRAM_DEPTH];
  term_pkg::vram_addr_t ext_addr_q;
  term_pkg::char_t      ext_data_q;
  term_pkg::vram_addr_t sweep_addr;
  logic                 ext_due;
  logic                 sweeping;
  logic                 pix_seen;
  int                   sweep_idx;
  int                   pix_gap;
  int                   err_cnt = 0;
  int                   check_cnt = 0;
  int                   clear_cnt = 0;
  int                   writes_seen = 0;

  assign errors      = err_cnt;
  assign checks      = check_cnt;
  assign clears_done = clear_cnt;

  task automatic check_cond(input bit ok, input string msg);
    check_cnt++;
    if (!ok) begin
      err_cnt++;
      $display("mismatch at %0t ns: %s", $time, msg);
    end
  endtask

  // whole memory against the model, plus the write count
  task automatic compare_memory();
    term_pkg::vram_addr_t a;
    for (int i = 0; i < `TERM_VRAM_DEPTH; i++) begin
      a = term_pkg::vram_addr_t'(i);
      check_cond(actual_mem[a] === model_mem[a],
        $sformatf("cell %0d holds %h, model %h", i, actual_mem[a], model_mem[a]));
    end
    check_cond(writes_seen == exp_writes,
      $sformatf("%0d port writes seen, %0d expected", writes_seen, exp_writes));
  endtask

  // ====================
  // compare on the falling edge
  // ====================

  // everything is settled half a cycle after the rising edge
  always @(negedge clk) begin
    if (!arst_n) begin
      ext_due   = 1'b0;
      sweeping  = 1'b0;
      sweep_idx = 0;
      pix_gap   = 0;
      pix_seen  = 1'b0;
    end else begin
      if (vram_we) begin
        actual_mem[vram_addr] = vram_data;
        writes_seen++;
      end
      if (ext_due) begin
        // accepted last cycle, must be on the port now
        check_cond(vram_we && vram_addr == ext_addr_q && vram_data == ext_data_q,
          $sformatf("external write %h at %0d, port we %b %h at %0d",
            ext_data_q, ext_addr_q, vram_we, vram_data, vram_addr));
        model_mem[ext_addr_q] = ext_data_q;
        ext_due = 1'b0;
      end else if (sweeping) begin
        sweep_addr = term_pkg::vram_addr_t'(sweep_idx);
        check_cond(vram_we && busy && vram_addr == sweep_addr && vram_data == blank,
          $sformatf("sweep cell %0d, port we %b %h at %0d busy %b",
            sweep_idx, vram_we, vram_data, vram_addr, busy));
        model_mem[sweep_addr] = blank;
        sweep_idx++;
        if (sweep_idx == `TERM_VRAM_DEPTH) begin
          sweeping = 1'b0;
          clear_cnt++;
        end
      end else if (vram_we) begin
        // only an owed clear may start a sweep, and at cell 0
        if (clear_cnt < clears_expected && vram_addr == '0 && vram_data == blank) begin
          check_cond(busy, "busy low at sweep start");
          model_mem[0] = blank;
          sweep_idx    = 1;
          sweeping     = 1'b1;
        end else begin
          check_cond(1'b0, $sformatf("unexpected write of %h at %0d", vram_data, vram_addr));
        end
      end
      // taken at the next edge, on the port one cycle later
      if (char_we && !busy) begin
        ext_due    = 1'b1;
        ext_addr_q = char_addr;
        ext_data_q = char_data;
      end
      // pixel enable period
      if (pix_en) begin
        if (pix_seen) begin
          check_cond(pix_gap == `TERM_PRESCALE - 1,
            $sformatf("pix_en after %0d cycles", pix_gap + 1));
        end
        pix_seen = 1'b1;
        pix_gap  = 0;
      end else if (pix_seen) begin
        pix_gap++;
        check_cond(pix_gap < `TERM_PRESCALE, "pix_en pulse missing");
      end
      check_cond(led[3] == pix_en && led[2] == busy,
        $sformatf("led %b with pix_en %b busy %b", led, pix_en, busy));
      if (hold_check) begin
        check_cond(led[1:0] == hold_led, $sformatf("button leds moved to %b", led[1:0]));
      end
      if (mem_check) begin
        compare_memory();
      end
    end
  end

endmodule

//--- term_front_top.sv
/*
  character terminal front end
  clock enables, button debounce, clear handshake
  and the character memory write port
*/

module term_front_top (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 btn_rst,
  input  logic                 btn_cls,
  input  logic                 char_we,
  input  term_pkg::vram_addr_t char_addr,
  input  term_pkg::char_t      char_data,
  output logic                 pix_en,
  output logic                 vram_we,
  output term_pkg::vram_addr_t vram_addr,
  output term_pkg::char_t      vram_data,
  output logic                 busy,
  output logic [3:0]           led
);

  logic sample_tick;
  logic sys_rst_n;
  logic cls_level;
  logic cls_req;
  logic cls_ack;

  // ====================
  // timing
  // ====================

  tick_timer tick_timer_i (
    .clk         (clk),
    .arst_n      (arst_n),
    .pix_en      (pix_en),
    .sample_tick (sample_tick)
  );

  // ====================
  // buttons
  // ====================

  // system held in reset until the button level settles high
  button_debounce #(
    .reset_level (1'b0)
  ) rst_debounce_i (
    .clk         (clk),
    .arst_n      (arst_n),
    .sample_tick (sample_tick),
    .btn_raw     (btn_rst),
    .btn_level   (sys_rst_n)
  );

  // clear button, active low
  button_debounce #(
    .reset_level (1'b1)
  ) cls_debounce_i (
    .clk         (clk),
    .arst_n      (arst_n),
    .sample_tick (sample_tick),
    .btn_raw     (btn_cls),
    .btn_level   (cls_level)
  );

  // ====================
  // clear path
  // ====================

  clear_sequencer clear_sequencer_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .sys_rst_n (sys_rst_n),
    .cls_level (cls_level),
    .cls_ack   (cls_ack),
    .cls_req   (cls_req)
  );

  vram_clear vram_clear_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .sys_rst_n (sys_rst_n),
    .cls_req   (cls_req),
    .cls_ack   (cls_ack),
    .char_we   (char_we),
    .char_addr (char_addr),
    .char_data (char_data),
    .busy      (busy),
    .vram_we   (vram_we),
    .vram_addr (vram_addr),
    .vram_data (vram_data)
  );

  // status leds
  assign led = {pix_en, busy, cls_level, sys_rst_n};

endmodule

//--- vram_clear.sv
/*
  character memory clear engine
  sweeps the blank code over every cell on request and
  arbitrates the single write port with external writes
*/

`include "term_settings.svh"

module vram_clear (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 sys_rst_n,
  input  logic                 cls_req,
  output logic                 cls_ack,
  input  logic                 char_we,
  input  term_pkg::vram_addr_t char_addr,
  input  term_pkg::char_t      char_data,
  output logic                 busy,
  output logic                 vram_we,
  output term_pkg::vram_addr_t vram_addr,
  output term_pkg::char_t      vram_data
);

  localparam term_pkg::vram_addr_t last_addr =
    term_pkg::vram_addr_t'(`TERM_VRAM_DEPTH - 1);

  term_pkg::vram_addr_t sweep_addr_q;
  term_pkg::vram_addr_t ext_addr_q;
  term_pkg::char_t      ext_data_q;

  logic sweep_q;
  logic ack_q;
  logic ext_we_q;
  logic sweep_start;

  // new request, not already sweeping or acking
  assign sweep_start = cls_req & ~sweep_q & ~ack_q;

  // ====================
  // sweep and ack
  // ====================

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      sweep_q      <= 1'b0;
      ack_q        <= 1'b0;
      sweep_addr_q <= '0;
    end else if (!sys_rst_n) begin
      sweep_q      <= 1'b0;
      ack_q        <= 1'b0;
      sweep_addr_q <= '0;
    end else if (sweep_start) begin
      sweep_q      <= 1'b1;
      sweep_addr_q <= '0;
    end else if (sweep_q) begin
      // one blank write per cycle
      sweep_addr_q <= sweep_addr_q + 1'b1;
      if (sweep_addr_q == last_addr) begin
        sweep_q <= 1'b0;
        ack_q   <= 1'b1;
      end
    end else if (ack_q && !cls_req) begin
      // req dropped, finish the exchange
      ack_q <= 1'b0;
    end
  end

  // ====================
  // external writes
  // ====================

  // held off while busy, the writer keeps its request up
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ext_we_q <= 1'b0;
    end else if (!sys_rst_n) begin
      ext_we_q <= 1'b0;
    end else begin
      ext_we_q <= char_we & ~busy;
    end
  end

  // payload only
  always_ff @(posedge clk) begin
    if (char_we && !busy) begin
      ext_addr_q <= char_addr;
      ext_data_q <= char_data;
    end
  end

  // ====================
  // write port
  // ====================

  // an accepted external write lands before any sweep can start
  assign vram_we   = sweep_q | ext_we_q;
  assign vram_addr = sweep_q ? sweep_addr_q : ext_addr_q;
  assign vram_data = sweep_q ? term_pkg::char_t'(`TERM_BLANK_CODE) : ext_data_q;

  // from req seen until ack falls
  assign busy    = cls_req | sweep_q | ack_q;
  assign cls_ack = ack_q;

endmodule

//--- clear_sequencer.sv
/*
  clear sequencer
  turns clear presses and reset release into four-phase
  requests to the clear engine, one pending press kept
*/

module clear_sequencer (
  input  logic clk,
  input  logic arst_n,
  input  logic sys_rst_n,
  input  logic cls_level,
  input  logic cls_ack,
  output logic cls_req
);

  term_pkg::seq_state_t state_q;

  logic cls_level_q;
  logic sys_rst_q;
  logic pending_q;
  logic press_evt;
  logic release_evt;
  logic clear_evt;

  // ====================
  // event detect
  // ====================

  // history flops follow their inputs even during system reset
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      cls_level_q <= 1'b1;
      sys_rst_q   <= 1'b0;
    end else begin
      cls_level_q <= cls_level;
      sys_rst_q   <= sys_rst_n;
    end
  end

  // button is active low, press is a falling level
  assign press_evt   = cls_level_q & ~cls_level;
  // first cycle out of system reset
  assign release_evt = sys_rst_n & ~sys_rst_q;
  assign clear_evt   = press_evt | release_evt;

  // ====================
  // handshake FSM
  // ====================

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state_q   <= term_pkg::IDLE;
      pending_q <= 1'b0;
    end else if (!sys_rst_n) begin
      state_q   <= term_pkg::IDLE;
      pending_q <= 1'b0;
    end else begin
      case (state_q)
        term_pkg::IDLE: begin
          // new event or one left over from the last clear
          if (clear_evt || pending_q) begin
            state_q   <= term_pkg::REQ;
            pending_q <= 1'b0;
          end
        end
        term_pkg::REQ: begin
          if (clear_evt) pending_q <= 1'b1;
          // engine finished the sweep
          if (cls_ack) state_q <= term_pkg::WAIT_ACK_LOW;
        end
        term_pkg::WAIT_ACK_LOW: begin
          if (clear_evt) pending_q <= 1'b1;
          if (!cls_ack) state_q <= term_pkg::IDLE;
        end
        default: begin
          state_q <= term_pkg::IDLE;
        end
      endcase
    end
  end

  // req only in its own state, dropped as soon as ack is seen
  assign cls_req = state_q == term_pkg::REQ;

endmodule

//--- button_debounce.sv
/*
  push button debouncer
  two-flop synchronizer and a stable-count filter that
  moves the level only after a run of equal samples
*/

`include "term_settings.svh"

module button_debounce #(
  // level held while in reset and before the first press
  parameter bit reset_level = 1'b0
) (
  input  logic clk,
  input  logic arst_n,
  input  logic sample_tick,
  input  logic btn_raw,
  output logic btn_level
);

  localparam int unsigned cnt_w = $clog2(`TERM_STABLE_COUNT + 1);

  logic [1:0]       sync_q;
  logic [cnt_w-1:0] stable_cnt_q;
  logic             level_q;
  logic             sample_diff;

  // ====================
  // synchronizer
  // ====================

  // raw button is asynchronous to clk
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      sync_q <= {2{reset_level}};
    end else begin
      sync_q <= {sync_q[0], btn_raw};
    end
  end

  // synchronized sample disagrees with the current output
  assign sample_diff = sync_q[1] != level_q;

  // ====================
  // stable filter
  // ====================

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      stable_cnt_q <= '0;
      level_q      <= reset_level;
    end else if (sample_tick) begin
      if (sample_diff) begin
        // last sample of the run flips the output
        if (stable_cnt_q == cnt_w'(`TERM_STABLE_COUNT - 1)) begin
          level_q      <= sync_q[1];
          stable_cnt_q <= '0;
        end else begin
          stable_cnt_q <= stable_cnt_q + 1'b1;
        end
      end else begin
        // bounce back, start over
        stable_cnt_q <= '0;
      end
    end
  end

  assign btn_level = level_q;

endmodule

//--- tick_timer.sv
/*
  tick timer
  free-running dividers for the pixel clock enable and
  the slow debounce sample tick, both one-cycle pulses
*/

`include "term_settings.svh"

module tick_timer (
  input  logic clk,
  input  logic arst_n,
  output logic pix_en,
  output logic sample_tick
);

  localparam int unsigned pix_w    = $clog2(`TERM_PRESCALE + 1);
  localparam int unsigned sample_w = $clog2(`TERM_SAMPLE_DIV + 1);

  logic [pix_w-1:0]    pix_cnt_q;
  logic [sample_w-1:0] sample_cnt_q;

  // ====================
  // pixel enable
  // ====================

  // stands in for the divided video clock
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pix_cnt_q <= '0;
      pix_en    <= 1'b0;
    end else if (pix_cnt_q == pix_w'(`TERM_PRESCALE - 1)) begin
      pix_cnt_q <= '0;
      pix_en    <= 1'b1;
    end else begin
      pix_cnt_q <= pix_cnt_q + 1'b1;
      pix_en    <= 1'b0;
    end
  end

  // ====================
  // sample tick
  // ====================

  // paces the button filters
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      sample_cnt_q <= '0;
      sample_tick  <= 1'b0;
    end else if (sample_cnt_q == sample_w'(`TERM_SAMPLE_DIV - 1)) begin
      sample_cnt_q <= '0;
      sample_tick  <= 1'b1;
    end else begin
      sample_cnt_q <= sample_cnt_q + 1'b1;
      sample_tick  <= 1'b0;
    end
  end

endmodule

//--- term_pkg.sv
/*
  terminal front end types
  cell address, character code and clear sequencer states
*/

`include "term_settings.svh"

package term_pkg;

  // ====================
  // memory port types
  // ====================

  // one character cell address
  typedef logic [`TERM_VRAM_AW-1:0] vram_addr_t;

  // one character code, ascii
  typedef logic [7:0] char_t;

  // ====================
  // sequencer states
  // ====================

  // four-phase exchange with the clear engine
  //   IDLE          no request out
  //   REQ           req high, waiting for ack
  //   WAIT_ACK_LOW  req dropped, waiting for ack to fall
  typedef enum logic [1:0] {
    IDLE         = 2'd0,
    REQ          = 2'd1,
    WAIT_ACK_LOW = 2'd2
  } seq_state_t;

endpackage

//--- term_settings.svh
/*
  terminal front end settings
  clock division, debounce timing and character memory geometry
  shared by the RTL and the testbench model
*/

`ifndef TERM_SETTINGS_SVH
`define TERM_SETTINGS_SVH

// ====================
// clock division
// ====================

// clk cycles per pixel enable pulse
`define TERM_PRESCALE 4

// clk cycles per debounce sample tick
`define TERM_SAMPLE_DIV 16

// ====================
// debounce
// ====================

// equal samples in a row before the level moves
`define TERM_STABLE_COUNT 4

// ====================
// character memory
// ====================

`define TERM_VRAM_DEPTH 64
`define TERM_VRAM_AW 6

// ascii space, written to every cell on a clear
`define TERM_BLANK_CODE 8'h20

`endif
